// File: pwr_ctrl_pkg.sv
`default_nettype none

package pwr_ctrl_pkg;

   // --------------------
   // field widths
   // --------------------
   localparam int PMA_PWRST_W = 6;
   localparam int PIPE_PD_W   = 3;
   localparam int PIPE_RATE_W = 2;
   localparam int PMA_MODE_W  = 3;
   localparam int PMA_WIDTH_W = 3;

   typedef logic [PMA_PWRST_W-1:0] pma_pwrst_t;
   typedef logic [PIPE_PD_W-1:0]   pipe_pd_t;
   typedef logic [PIPE_RATE_W-1:0] pipe_rate_t;
   typedef logic [PMA_MODE_W-1:0]  pma_mode_t;
   typedef logic [PMA_WIDTH_W-1:0] pma_width_t;

   // --------------------
   // one-hot PMA power states
   // --------------------
   // all zero means no request or an unknown state after reset
   localparam pma_pwrst_t PMA_NONE = 6'b000000;
   localparam pma_pwrst_t PMA_A0   = 6'b000001;
   localparam pma_pwrst_t PMA_A1   = 6'b000010;
   localparam pma_pwrst_t PMA_A2   = 6'b000100;
   localparam pma_pwrst_t PMA_A3   = 6'b001000;
   localparam pma_pwrst_t PMA_A4   = 6'b010000;
   localparam pma_pwrst_t PMA_A5   = 6'b100000;

   // --------------------
   // USB4 PMA mode and width
   // --------------------
   // gen2 10G, gen3 20G, gen4 40G
   localparam pma_mode_t  USB4_GEN2_MODE  = 3'd0;
   localparam pma_mode_t  USB4_GEN3_MODE  = 3'd1;
   localparam pma_mode_t  USB4_GEN4_MODE  = 3'd2;
   localparam pma_width_t USB4_GEN2_WIDTH = 3'd1;
   localparam pma_width_t USB4_GEN3_WIDTH = 3'd2;
   localparam pma_width_t USB4_GEN4_WIDTH = 3'd3;

   // power FSM states
   // code 4 is not used
   typedef enum logic [2:0] {
      ST_STARTUP      = 3'h0,
      ST_IDLE         = 3'h1,
      ST_PWRST_CHG    = 3'h2,
      ST_ENTER_PD     = 3'h3,
      ST_WAIT_EXIT_PD = 3'h5,
      ST_EXIT_PD      = 3'h6,
      ST_L0P          = 3'h7
   } pwr_fsm_state_t;

endpackage

`default_nettype wire

// File: sync_stage.sv
`timescale 1ns/10ps
`default_nettype none

module sync_stage #(
   parameter int       SYNC_DEPTH  = 2,
   parameter type      payload_t   = logic,
   parameter payload_t RESET_VALUE = '0
) (
   input  wire logic     clk,
   input  wire logic     reset_n,
   input  wire payload_t d_in,
   output payload_t      d_out
);

   // flop chain, stage 0 is the metastable one
   payload_t sync_q [SYNC_DEPTH];

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         for (int i = 0; i < SYNC_DEPTH; i++)
         begin
            sync_q[i] <= RESET_VALUE;
         end
      end
      else
      begin
         sync_q[0] <= d_in;
         for (int i = 1; i < SYNC_DEPTH; i++)
         begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   assign d_out = sync_q[SYNC_DEPTH-1];

endmodule

`default_nettype wire

// File: pwr_req_decode.sv
`timescale 1ns/10ps
`default_nettype none

module pwr_req_decode (
   // only used to sample the assertion
   input  wire logic                    clk,
   input  wire pwr_ctrl_pkg::pipe_pd_t   pipe_pd,
   input  wire logic                    rx_standby,
   input  wire pwr_ctrl_pkg::pipe_rate_t pipe_rate,
   output pwr_ctrl_pkg::pma_pwrst_t      req_pma_pwrst,
   output pwr_ctrl_pkg::pma_mode_t       rate_mode,
   output pwr_ctrl_pkg::pma_width_t      rate_width
);

   // --------------------
   // PIPE power-down to PMA state
   // --------------------
   // 000 splits on rx standby into A5 or A0
   always_comb
   begin
      case (pipe_pd)
         3'b000:  req_pma_pwrst = rx_standby ? pwr_ctrl_pkg::PMA_A5 : pwr_ctrl_pkg::PMA_A0;
         3'b001:  req_pma_pwrst = pwr_ctrl_pkg::PMA_A1;
         3'b010:  req_pma_pwrst = pwr_ctrl_pkg::PMA_A1;
         3'b011:  req_pma_pwrst = pwr_ctrl_pkg::PMA_A3;
         3'b100:  req_pma_pwrst = pwr_ctrl_pkg::PMA_A2;
         3'b101:  req_pma_pwrst = pwr_ctrl_pkg::PMA_A4;
         default: req_pma_pwrst = pwr_ctrl_pkg::PMA_A0;
      endcase
   end

   // --------------------
   // PIPE rate to PMA mode / width
   // --------------------
   always_comb
   begin
      case (pipe_rate)
         2'b01:
         begin
            // gen3 at 20G
            rate_mode  = pwr_ctrl_pkg::USB4_GEN3_MODE;
            rate_width = pwr_ctrl_pkg::USB4_GEN3_WIDTH;
         end
         2'b10:
         begin
            // gen4 at 40G
            rate_mode  = pwr_ctrl_pkg::USB4_GEN4_MODE;
            rate_width = pwr_ctrl_pkg::USB4_GEN4_WIDTH;
         end
         default:
         begin
            // gen2 at 10G and the unused code
            rate_mode  = pwr_ctrl_pkg::USB4_GEN2_MODE;
            rate_width = pwr_ctrl_pkg::USB4_GEN2_WIDTH;
         end
      endcase
   end

   // an unknown input would quietly decode to A0 or gen2
   a_in_known: assert property (@(posedge clk)
      !$isunknown({pipe_pd, rx_standby, pipe_rate}));

endmodule

`default_nettype wire

// File: pwr_state_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module pwr_state_fsm (
   input  wire logic                     clk,
   input  wire logic                     reset_n,
   // decoded request and start-of-day rate settings
   input  wire pwr_ctrl_pkg::pma_pwrst_t  req_pma_pwrst,
   input  wire pwr_ctrl_pkg::pma_mode_t   rate_mode,
   input  wire pwr_ctrl_pkg::pma_width_t  rate_width,
   // synchronized status
   input  wire logic                     pll_ready,
   input  wire logic                     clk_en_ack,
   input  wire logic                     clk_en_ack_low,
   input  wire logic                     pclk_running,
   // PMA power handshake
   input  wire pwr_ctrl_pkg::pma_pwrst_t  pma_pwr_state_ack,
   output pwr_ctrl_pkg::pma_pwrst_t       pma_pwr_state_req,
   output logic                          pma_xcvr_pll_clk_en,
   output logic                          pwr_chg_done,
   output logic                          pipe_rx_en,
   output logic                          ln_l0p_en,
   output pwr_ctrl_pkg::pma_mode_t        pma_standard_mode,
   output pwr_ctrl_pkg::pma_width_t       pma_data_width,
   output pwr_ctrl_pkg::pwr_fsm_state_t   state
);

   // state the PMA has last acknowledged
   pwr_ctrl_pkg::pma_pwrst_t cur_pma_pwrst;
   // pending request goes to A3 or A4
   logic pd_req;
   // high only for the first clock out of reset
   logic start_of_day;

   logic req_differs;
   logic ack_idle;

   assign req_differs = (cur_pma_pwrst != req_pma_pwrst);
   // previous handshake fully closed by the PMA
   assign ack_idle    = (pma_pwr_state_ack == pwr_ctrl_pkg::PMA_NONE);

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         state               <= pwr_ctrl_pkg::ST_STARTUP;
         cur_pma_pwrst       <= pwr_ctrl_pkg::PMA_NONE;
         pd_req              <= 1'b0;
         start_of_day        <= 1'b1;
         pma_pwr_state_req   <= pwr_ctrl_pkg::PMA_NONE;
         pma_xcvr_pll_clk_en <= 1'b0;
         pwr_chg_done        <= 1'b0;
         pipe_rx_en          <= 1'b0;
         ln_l0p_en           <= 1'b0;
         pma_standard_mode   <= '0;
         pma_data_width      <= '0;
      end
      else
      begin
         start_of_day <= 1'b0;

         case (state)
            // --------------------
            // bring-up
            // --------------------
            pwr_ctrl_pkg::ST_STARTUP:
            begin
               // USB4 rate is fixed while out of reset, grab it once
               if (start_of_day)
               begin
                  pma_standard_mode <= rate_mode;
                  pma_data_width    <= rate_width;
               end
               // common PLL up, turn on lane clock
               if (pll_ready)
               begin
                  pma_xcvr_pll_clk_en <= 1'b1;
               end
               if (clk_en_ack && pclk_running)
               begin
                  state <= pwr_ctrl_pkg::ST_IDLE;
               end
            end

            // idle and L0p both wait for a new target state
            pwr_ctrl_pkg::ST_IDLE,
            pwr_ctrl_pkg::ST_L0P:
            begin
               if (req_differs && ack_idle)
               begin
                  state             <= pwr_ctrl_pkg::ST_PWRST_CHG;
                  pma_pwr_state_req <= req_pma_pwrst;
                  pd_req            <= (req_pma_pwrst == pwr_ctrl_pkg::PMA_A3) ||
                                       (req_pma_pwrst == pwr_ctrl_pkg::PMA_A4);
                  // set for A5, cleared when leaving L0p
                  ln_l0p_en         <= (req_pma_pwrst == pwr_ctrl_pkg::PMA_A5);
               end
            end

            // --------------------
            // PMA power handshake
            // --------------------
            pwr_ctrl_pkg::ST_PWRST_CHG:
            begin
               if (pma_pwr_state_ack == pma_pwr_state_req)
               begin
                  pma_pwr_state_req <= pwr_ctrl_pkg::PMA_NONE;
                  cur_pma_pwrst     <= pma_pwr_state_req;
                  if (pd_req)
                  begin
                     // done toggles later, once the PLL clock is off
                     state               <= pwr_ctrl_pkg::ST_ENTER_PD;
                     pma_xcvr_pll_clk_en <= 1'b0;
                     pipe_rx_en          <= 1'b0;
                  end
                  else if (ln_l0p_en)
                  begin
                     state        <= pwr_ctrl_pkg::ST_L0P;
                     pwr_chg_done <= ~pwr_chg_done;
                     pipe_rx_en   <= 1'b0;
                  end
                  else
                  begin
                     state        <= pwr_ctrl_pkg::ST_IDLE;
                     pwr_chg_done <= ~pwr_chg_done;
                     // receiver only runs in A0 and A1
                     pipe_rx_en   <= (pma_pwr_state_req == pwr_ctrl_pkg::PMA_A0) ||
                                     (pma_pwr_state_req == pwr_ctrl_pkg::PMA_A1);
                  end
               end
            end

            // --------------------
            // power-down entry and exit
            // --------------------
            pwr_ctrl_pkg::ST_ENTER_PD:
            begin
               // aggregated ack low means every lane PLL clock is off
               if (!clk_en_ack_low)
               begin
                  state        <= pwr_ctrl_pkg::ST_WAIT_EXIT_PD;
                  pwr_chg_done <= ~pwr_chg_done;
               end
            end

            pwr_ctrl_pkg::ST_WAIT_EXIT_PD:
            begin
               if (req_differs && pll_ready)
               begin
                  state               <= pwr_ctrl_pkg::ST_EXIT_PD;
                  pma_xcvr_pll_clk_en <= 1'b1;
               end
            end

            pwr_ctrl_pkg::ST_EXIT_PD:
            begin
               // clock back on, now ask for the new state
               if (clk_en_ack && ack_idle)
               begin
                  state             <= pwr_ctrl_pkg::ST_PWRST_CHG;
                  pd_req            <= 1'b0;
                  pma_pwr_state_req <= req_pma_pwrst;
               end
            end

            default:
            begin
               state <= pwr_ctrl_pkg::ST_IDLE;
            end
         endcase
      end
   end

   a_req_onehot0: assert property (@(posedge clk) disable iff (!reset_n)
      $onehot0(pma_pwr_state_req));

   // rx path stays off through the whole power-down
   a_no_rx_in_pd: assert property (@(posedge clk) disable iff (!reset_n)
      (state == pwr_ctrl_pkg::ST_WAIT_EXIT_PD) |-> !pipe_rx_en);

endmodule

`default_nettype wire

// File: pwr_rate_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module pwr_rate_ctrl #(
   parameter int SYNC_DEPTH = 2
) (
   input  wire logic                     clk,
   input  wire logic                     reset_n,
   // PIPE side
   input  wire pwr_ctrl_pkg::pipe_pd_t    pipe_powerdown,
   input  wire pwr_ctrl_pkg::pipe_rate_t  pipe_rate,
   input  wire logic                     pipe_rx_standby,
   input  wire logic                     pipe_clk_running,
   // PMA side
   input  wire logic                     pma_pll_ready,
   input  wire pwr_ctrl_pkg::pma_pwrst_t  pma_pwr_state_ack,
   input  wire logic                     pma_xcvr_pll_clk_en_ack,
   input  wire logic                     pma_xcvr_pll_clk_en_ack_low,
   output logic                          pwr_chg_done,
   output logic                          pipe_rx_en,
   output logic                          ln_l0p_en,
   output logic                          rx_standby_status,
   output pwr_ctrl_pkg::pma_width_t       pma_data_width,
   output pwr_ctrl_pkg::pma_mode_t        pma_standard_mode,
   output pwr_ctrl_pkg::pma_pwrst_t       pma_pwr_state_req,
   output logic                          pma_xcvr_pll_clk_en
);

   // synchronized request bundle, {standby, power-down}
   logic [3:0]                  req_sync;
   logic                        pll_ready_sync;
   logic                        clk_en_ack_sync;
   logic                        clk_en_ack_low_sync;
   logic                        pclk_running_sync;
   pwr_ctrl_pkg::pma_pwrst_t     req_pma_pwrst;
   pwr_ctrl_pkg::pma_mode_t      rate_mode;
   pwr_ctrl_pkg::pma_width_t     rate_width;
   pwr_ctrl_pkg::pwr_fsm_state_t fsm_state;

   // --------------------
   // input synchronizers
   // --------------------
   // resets to P2 (010) with standby low
   sync_stage #(.SYNC_DEPTH(SYNC_DEPTH), .payload_t(logic [3:0]), .RESET_VALUE(4'b0010))
      u_sync_req (
         .clk     (clk),
         .reset_n (reset_n),
         .d_in    ({pipe_rx_standby, pipe_powerdown}),
         .d_out   (req_sync)
      );

   sync_stage #(.SYNC_DEPTH(SYNC_DEPTH), .payload_t(logic), .RESET_VALUE(1'b0))
      u_sync_pll_ready (
         .clk     (clk),
         .reset_n (reset_n),
         .d_in    (pma_pll_ready),
         .d_out   (pll_ready_sync)
      );

   sync_stage #(.SYNC_DEPTH(SYNC_DEPTH), .payload_t(logic), .RESET_VALUE(1'b0))
      u_sync_clk_en_ack (
         .clk     (clk),
         .reset_n (reset_n),
         .d_in    (pma_xcvr_pll_clk_en_ack),
         .d_out   (clk_en_ack_sync)
      );

   sync_stage #(.SYNC_DEPTH(SYNC_DEPTH), .payload_t(logic), .RESET_VALUE(1'b0))
      u_sync_clk_en_ack_low (
         .clk     (clk),
         .reset_n (reset_n),
         .d_in    (pma_xcvr_pll_clk_en_ack_low),
         .d_out   (clk_en_ack_low_sync)
      );

   sync_stage #(.SYNC_DEPTH(SYNC_DEPTH), .payload_t(logic), .RESET_VALUE(1'b0))
      u_sync_pclk_running (
         .clk     (clk),
         .reset_n (reset_n),
         .d_in    (pipe_clk_running),
         .d_out   (pclk_running_sync)
      );

   // --------------------
   // decode and FSM
   // --------------------
   pwr_req_decode u_pwr_req_decode (
      .clk           (clk),
      .pipe_pd       (req_sync[2:0]),
      .rx_standby    (req_sync[3]),
      .pipe_rate     (pipe_rate),
      .req_pma_pwrst (req_pma_pwrst),
      .rate_mode     (rate_mode),
      .rate_width    (rate_width)
   );

   pwr_state_fsm u_pwr_state_fsm (
      .clk                 (clk),
      .reset_n             (reset_n),
      .req_pma_pwrst       (req_pma_pwrst),
      .rate_mode           (rate_mode),
      .rate_width          (rate_width),
      .pll_ready           (pll_ready_sync),
      .clk_en_ack          (clk_en_ack_sync),
      .clk_en_ack_low      (clk_en_ack_low_sync),
      .pclk_running        (pclk_running_sync),
      .pma_pwr_state_ack   (pma_pwr_state_ack),
      .pma_pwr_state_req   (pma_pwr_state_req),
      .pma_xcvr_pll_clk_en (pma_xcvr_pll_clk_en),
      .pwr_chg_done        (pwr_chg_done),
      .pipe_rx_en          (pipe_rx_en),
      .ln_l0p_en           (ln_l0p_en),
      .pma_standard_mode   (pma_standard_mode),
      .pma_data_width      (pma_data_width),
      .state               (fsm_state)
   );

   // standby status simply mirrors the L0p flag
   assign rx_standby_status = ln_l0p_en;

   // lane PLL clock must stay off from power-down entry until exit starts
   a_pll_off_in_pd: assert property (@(posedge clk) disable iff (!reset_n)
      (fsm_state inside {pwr_ctrl_pkg::ST_ENTER_PD, pwr_ctrl_pkg::ST_WAIT_EXIT_PD})
      |-> !pma_xcvr_pll_clk_en);

endmodule

`default_nettype wire

// File: tb_pwr_rate_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pwr_rate_ctrl;

   localparam int SYNC_DEPTH = 2;
   localparam int NUM_DRAWS  = 60;
   // cycles allowed for any single wait
   localparam int TIMEOUT    = 400;

   logic                     clk = 1'b0;
   logic                     reset_n;
   pwr_ctrl_pkg::pipe_pd_t   pipe_powerdown;
   pwr_ctrl_pkg::pipe_rate_t pipe_rate;
   logic                     pipe_rx_standby;
   logic                     pipe_clk_running;
   logic                     pma_pll_ready;
   pwr_ctrl_pkg::pma_pwrst_t pma_pwr_state_ack = '0;
   logic                     pma_xcvr_pll_clk_en_ack = 1'b0;
   logic                     pma_xcvr_pll_clk_en_ack_low = 1'b0;
   logic                     pwr_chg_done;
   logic                     pipe_rx_en;
   logic                     ln_l0p_en;
   logic                     rx_standby_status;
   pwr_ctrl_pkg::pma_width_t pma_data_width;
   pwr_ctrl_pkg::pma_mode_t  pma_standard_mode;
   pwr_ctrl_pkg::pma_pwrst_t pma_pwr_state_req;
   logic                     pma_xcvr_pll_clk_en;

   int checks;
   int errors;
   // reference model state
   pwr_ctrl_pkg::pma_pwrst_t cur_state;
   logic                     done_exp;
   // PMA responder countdowns
   int pwr_wait = 0;
   int en_wait  = 0;
   int low_wait = 0;

   pwr_rate_ctrl #(.SYNC_DEPTH(SYNC_DEPTH)) u_pwr_rate_ctrl (
      .clk                         (clk),
      .reset_n                     (reset_n),
      .pipe_powerdown              (pipe_powerdown),
      .pipe_rate                   (pipe_rate),
      .pipe_rx_standby             (pipe_rx_standby),
      .pipe_clk_running            (pipe_clk_running),
      .pma_pll_ready               (pma_pll_ready),
      .pma_pwr_state_ack           (pma_pwr_state_ack),
      .pma_xcvr_pll_clk_en_ack     (pma_xcvr_pll_clk_en_ack),
      .pma_xcvr_pll_clk_en_ack_low (pma_xcvr_pll_clk_en_ack_low),
      .pwr_chg_done                (pwr_chg_done),
      .pipe_rx_en                  (pipe_rx_en),
      .ln_l0p_en                   (ln_l0p_en),
      .rx_standby_status           (rx_standby_status),
      .pma_data_width              (pma_data_width),
      .pma_standard_mode           (pma_standard_mode),
      .pma_pwr_state_req           (pma_pwr_state_req),
      .pma_xcvr_pll_clk_en         (pma_xcvr_pll_clk_en)
   );

   // 10 ns clock
   always #5 clk = ~clk;

   // --------------------
   // reference model
   // --------------------
   // PIPE power-down code plus standby to one-hot PMA state
   function automatic pwr_ctrl_pkg::pma_pwrst_t expected_pwrst(input logic [2:0] pd,
                                                              input logic sb);
      case (pd)
         3'b000:  return sb ? pwr_ctrl_pkg::PMA_A5 : pwr_ctrl_pkg::PMA_A0;
         3'b001,
         3'b010:  return pwr_ctrl_pkg::PMA_A1;
         3'b011:  return pwr_ctrl_pkg::PMA_A3;
         3'b100:  return pwr_ctrl_pkg::PMA_A2;
         3'b101:  return pwr_ctrl_pkg::PMA_A4;
         default: return pwr_ctrl_pkg::PMA_A0;
      endcase
   endfunction

   // {mode, width} for a PIPE rate
   function automatic logic [5:0] expected_rate(input logic [1:0] rate);
      if (rate == 2'b01)
         return {pwr_ctrl_pkg::USB4_GEN3_MODE, pwr_ctrl_pkg::USB4_GEN3_WIDTH};
      else if (rate == 2'b10)
         return {pwr_ctrl_pkg::USB4_GEN4_MODE, pwr_ctrl_pkg::USB4_GEN4_WIDTH};
      else
         return {pwr_ctrl_pkg::USB4_GEN2_MODE, pwr_ctrl_pkg::USB4_GEN2_WIDTH};
   endfunction

   // --------------------
   // PMA responder
   // --------------------
   // each ack follows its request after 1 to 8 cycles
   always @(negedge clk)
   begin
      if (pma_pwr_state_ack != pma_pwr_state_req)
      begin
         if (pwr_wait == 0)
            pwr_wait = $urandom_range(8, 1);
         pwr_wait--;
         if (pwr_wait == 0)
            pma_pwr_state_ack = pma_pwr_state_req;
      end
      // both PLL clock acks track the enable level on their own
      if (pma_xcvr_pll_clk_en_ack != pma_xcvr_pll_clk_en)
      begin
         if (en_wait == 0)
            en_wait = $urandom_range(8, 1);
         en_wait--;
         if (en_wait == 0)
            pma_xcvr_pll_clk_en_ack = pma_xcvr_pll_clk_en;
      end
      if (pma_xcvr_pll_clk_en_ack_low != pma_xcvr_pll_clk_en)
      begin
         if (low_wait == 0)
            low_wait = $urandom_range(8, 1);
         low_wait--;
         if (low_wait == 0)
            pma_xcvr_pll_clk_en_ack_low = pma_xcvr_pll_clk_en;
      end
   end

   // --------------------
   // checking helpers
   // --------------------
   task automatic expect_equal(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("Mismatch %s: expected %0h, actual %0h", what, exp, act);
      end
   endtask

   task automatic finish_run();
      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   endtask

   task automatic timeout_abort(input string what);
      errors++;
      $display("Timeout waiting for %s", what);
      finish_run();
   endtask

   // every control output packed and expected zero
   task automatic check_reset_outputs(input string when);
      expect_equal(when, 32'h0, 32'({pma_pwr_state_req, pma_xcvr_pll_clk_en, pwr_chg_done,
                   pipe_rx_en, ln_l0p_en, rx_standby_status, pma_standard_mode,
                   pma_data_width}));
   endtask

   // one full power change driven at a falling edge
   task automatic run_change(input logic [2:0] pd, input logic sb);
      pwr_ctrl_pkg::pma_pwrst_t exp_state;
      logic [5:0]               exp_rate;
      logic                     exp_pd;
      int                       cnt;
      exp_state = expected_pwrst(pd, sb);
      exp_rate  = expected_rate(pipe_rate);
      exp_pd    = (exp_state == pwr_ctrl_pkg::PMA_A3) || (exp_state == pwr_ctrl_pkg::PMA_A4);
      pipe_powerdown  = pd;
      pipe_rx_standby = sb;
      cnt = 0;
      while (pma_pwr_state_req == pwr_ctrl_pkg::PMA_NONE)
      begin
         // no stray toggle since the last change
         expect_equal("done stable", 32'(done_exp), 32'(pwr_chg_done));
         // L0p flags hold until the FSM takes the request
         if (cur_state == pwr_ctrl_pkg::PMA_A5)
         begin
            expect_equal("l0p held", 32'h1, 32'(ln_l0p_en));
            expect_equal("standby status held", 32'h1, 32'(rx_standby_status));
         end
         @(negedge clk);
         cnt++;
         if (cnt > TIMEOUT)
            timeout_abort("PMA power state request");
      end
      expect_equal("pwr state req", 32'(exp_state), 32'(pma_pwr_state_req));
      // lane clock is back on before any request
      expect_equal("pll clk en at req", 32'h1, 32'(pma_xcvr_pll_clk_en));
      expect_equal("standard mode", 32'(exp_rate[5:3]), 32'(pma_standard_mode));
      expect_equal("data width", 32'(exp_rate[2:0]), 32'(pma_data_width));
      cnt = 0;
      while (pwr_chg_done == done_exp)
      begin
         @(negedge clk);
         cnt++;
         if (cnt > TIMEOUT)
            timeout_abort("power change done toggle");
      end
      done_exp = ~done_exp;
      expect_equal("rx en", 32'((exp_state == pwr_ctrl_pkg::PMA_A0) ||
                   (exp_state == pwr_ctrl_pkg::PMA_A1)), 32'(pipe_rx_en));
      // power-down drops the clock before done
      expect_equal("pll clk en at done", 32'(!exp_pd), 32'(pma_xcvr_pll_clk_en));
      expect_equal("l0p", 32'(exp_state == pwr_ctrl_pkg::PMA_A5), 32'(ln_l0p_en));
      expect_equal("standby status", 32'(exp_state == pwr_ctrl_pkg::PMA_A5),
                   32'(rx_standby_status));
      cur_state = exp_state;
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial
   begin
      logic [2:0] pd;
      logic       sb;
      int         hold;
      void'($urandom(32'hd827));
      checks           = 0;
      errors           = 0;
      cur_state        = pwr_ctrl_pkg::PMA_NONE;
      done_exp         = 1'b0;
      reset_n          = 1'b0;
      pipe_rate        = 2'($urandom_range(3, 0));
      pipe_powerdown   = 3'b000;
      pipe_rx_standby  = 1'b0;
      pipe_clk_running = 1'b0;
      pma_pll_ready    = 1'b0;

      // 2 cycles of reset
      @(negedge clk);
      check_reset_outputs("outputs in reset");
      @(negedge clk);
      reset_n = 1'b1;
      #1;
      check_reset_outputs("outputs at reset release");

      // PLL and PCLK come up late
      hold = $urandom_range(12, 2);
      repeat (hold) @(negedge clk);
      pma_pll_ready = 1'b1;
      hold = $urandom_range(12, 1);
      repeat (hold) @(negedge clk);
      pipe_clk_running = 1'b1;

      // first change from reset into A0
      run_change(3'b000, 1'b0);

      for (int i = 0; i < NUM_DRAWS; i++)
      begin
         if ((cur_state == pwr_ctrl_pkg::PMA_A3) || (cur_state == pwr_ctrl_pkg::PMA_A4))
         begin
            // exit from power-down only to A0, A1 or A2
            sb = 1'($urandom_range(1, 0));
            case ($urandom_range(3, 0))
               0: pd = 3'b001;
               1: pd = 3'b010;
               2: pd = 3'b100;
               default:
               begin
                  pd = 3'b000;
                  sb = 1'b0;
               end
            endcase
         end
         else
         begin
            pd = 3'($urandom_range(7, 0));
            sb = 1'($urandom_range(1, 0));
         end
         // skip a request for the current state
         if (expected_pwrst(pd, sb) != cur_state)
            run_change(pd, sb);
      end

      // done must not move in the quiet tail
      repeat (20) @(negedge clk);
      expect_equal("done stable at end", 32'(done_exp), 32'(pwr_chg_done));
      finish_run();
   end

endmodule

`default_nettype wire

// File: vlog.f
pwr_ctrl_pkg.sv
sync_stage.sv
pwr_req_decode.sv
pwr_state_fsm.sv
pwr_rate_ctrl.sv
tb_pwr_rate_ctrl.sv

// File: Makefile
# Verilator flow for the lane power controller

VERILATOR ?= verilator
TOP       ?= tb_pwr_rate_ctrl
LINT_TOP  ?= pwr_rate_ctrl
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
